// File: bench/ubm_tb.sv
//**************************************************************************
// testbench of the serial bus bridge: clock, reset, serial driver,
// tx monitor, bus memory model, reference model, checks, watchdog
//**************************************************************************
`include "ubm_defines.svh"

module ubm_tb;

  typedef ubm_pkg::byte_t byte_q_t[$];

  localparam int N_SENT      = 33;   // bytes driven on rx over all tests
  localparam int N_EXP       = 39;   // bytes expected back on tx
  localparam int WDOG_CYCLES = (N_SENT + N_EXP) * 40 + 2000;

  logic           clk;
  logic           UART_RST;
  logic           rx;
  logic           tx;
  wire [7:0]      bus_data;
  ubm_pkg::addr_t bus_add;
  logic           bus_wr;
  logic           bus_rd;

  ubm_pkg::byte_t mem [256];       // bus side memory
  ubm_pkg::byte_t ref_mem [256];   // reference copy
  ubm_pkg::len_t  ref_len;
  ubm_pkg::addr_t ref_add;
  logic [1:0]     rd_cnt;          // read strobe still recent
  byte_q_t        rx_q;
  byte_q_t        exp_q;
  byte_q_t        no_par;
  logic [40:0]    exp_bus_q[$];    // {wr, add, wdata}
  event           byte_ev;
  int             got_cnt   = 0;
  int             exp_total = 0;
  int             err_data  = 0;
  int             err_bus   = 0;
  int             seed      = 21;

  ubm_top i_dut (
    .clk(clk), .UART_RST(UART_RST), .rx(rx), .tx(tx), .bus_data(bus_data),
    .bus_add(bus_add), .bus_wr(bus_wr), .bus_rd(bus_rd)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic ubm_pkg::byte_t fill_pattern(input int unsigned a);
    return 8'(a * 37 + 11) ^ 8'h5C;
  endfunction

  // expected answer stream of one command, updates the model state
  function automatic byte_q_t ubm_ref_cmd(input ubm_pkg::byte_t cmd, input byte_q_t par);
    byte_q_t        ans;
    ubm_pkg::addr_t a;
    ans = {};
    case (cmd)
      `UBM_CMD_LEN: ref_len = {par[1], par[0]};
      `UBM_CMD_ADD: ref_add = {par[3], par[2], par[1], par[0]};
      `UBM_CMD_WR: begin
        for (int i = 0; i < ref_len; i++) begin
          a = ref_add + i;
          ref_mem[a[7:0]] = par[i];
        end
      end
      `UBM_CMD_RD: begin
        for (int i = 0; i < ref_len; i++) begin
          a = ref_add + i;
          ans.push_back(ref_mem[a[7:0]]);
        end
      end
      default: return ans;   // no answer at all
    endcase
    ans.push_back(`UBM_ACK0);
    ans.push_back(`UBM_ACK1);
    ans.push_back(`UBM_ACK2);
    return ans;
  endfunction

  // 8N1 frame, 4 clocks per bit
  task automatic send_byte(input ubm_pkg::byte_t b);
    @(negedge clk);
    rx = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (4) @(negedge clk);
    end
    rx = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic run_cmd(input ubm_pkg::byte_t cmd, input byte_q_t par);
    byte_q_t        ans;
    ubm_pkg::addr_t a;
    if (cmd == `UBM_CMD_WR || cmd == `UBM_CMD_RD) begin
      for (int i = 0; i < ref_len; i++) begin
        a = ref_add + i;
        if (cmd == `UBM_CMD_WR)
          exp_bus_q.push_back({1'b1, a, par[i]});
        else
          exp_bus_q.push_back({1'b0, a, 8'h00});
      end
    end
    ans = ubm_ref_cmd(cmd, par);
    foreach (ans[i]) exp_q.push_back(ans[i]);
    exp_total += ans.size();
    send_byte(cmd);
    foreach (par[i]) send_byte(par[i]);
    if (ans.size() == 0)
      repeat (100) @(negedge clk);   // quiet line expected
    else
      wait (got_cnt >= exp_total);
  endtask

  task automatic report_counts();
    $display("errors: %0d tx data, %0d bus, %0d tx bytes checked", err_data, err_bus, got_cnt);
  endtask

  // bus memory model
  always @(negedge clk) begin
    if (bus_wr)
      mem[bus_add[7:0]] <= bus_data;
    if (bus_rd)
      rd_cnt <= 2'd3;
    else if (rd_cnt != 2'd0)
      rd_cnt <= rd_cnt - 1'b1;
  end
  assign bus_data = (rd_cnt != 2'd0) ? mem[bus_add[7:0]] : 8'hzz;

  always @(negedge clk) begin : bus_check
    logic [40:0] e;
    if (!UART_RST) begin
      assert (!(bus_wr && bus_rd)) else begin
        $display("bus_wr and bus_rd were high in the same cycle");
        err_bus++;
      end
      assert (bus_wr || rd_cnt != 2'd0 || bus_data === 8'hzz) else begin
        $display("bus_data driven by the DUT while bus_wr is low");
        err_bus++;
      end
      if (bus_wr || bus_rd) begin
        assert (exp_bus_q.size() != 0) else begin
          $display("bus strobe seen while none was due");
          err_bus++;
        end
        if (exp_bus_q.size() != 0) begin
          e = exp_bus_q.pop_front();
          assert (bus_wr == e[40]) else begin
            $display("ERR bus_wr: got %h expected %h", bus_wr, e[40]);
            err_bus++;
          end
          assert (bus_add == e[39:8]) else begin
            $display("ERR bus_add: got %h expected %h", bus_add, e[39:8]);
            err_bus++;
          end
          if (bus_wr) begin
            assert (bus_data === e[7:0]) else begin
              $display("ERR bus_data: got %h expected %h", bus_data, e[7:0]);
              err_bus++;
            end
          end
        end
      end
    end
  end

  // tx decoder, samples mid-bit on falling clock edges
  initial begin : tx_monitor
    ubm_pkg::byte_t b;
    forever begin
      @(negedge tx);
      repeat (2) @(negedge clk);
      if (tx == 1'b0) begin
        for (int i = 0; i < 8; i++) begin
          repeat (4) @(negedge clk);
          b[i] = tx;
        end
        repeat (4) @(negedge clk);
        if (tx !== 1'b1) begin
          $display("stop bit low on tx, frame dropped");
          err_data++;
        end else begin
          rx_q.push_back(b);
          -> byte_ev;
        end
      end
    end
  end

  initial begin : compare_bytes
    ubm_pkg::byte_t got;
    ubm_pkg::byte_t want;
    forever begin
      @(byte_ev);
      while (rx_q.size() != 0) begin
        got = rx_q.pop_front();
        assert (exp_q.size() != 0) else begin
          $display("byte received on tx while no answer was due");
          err_data++;
        end
        if (exp_q.size() != 0) begin
          want = exp_q.pop_front();
          assert (got === want) else begin
            $display("ERR tx_byte: got %h expected %h", got, want);
            err_data++;
          end
        end
        got_cnt++;
      end
    end
  end

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", WDOG_CYCLES);
    report_counts();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main_seq
    byte_q_t        data;
    ubm_pkg::addr_t base;
    UART_RST = 1'b1;
    rx       = 1'b1;
    rd_cnt   = '0;
    ref_len  = 16'd1;
    ref_add  = '0;
    no_par   = {};
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_pattern(i);
      ref_mem[i] = fill_pattern(i);
    end
    repeat (16) @(negedge clk);
    UART_RST = 1'b0;
    repeat (4) @(negedge clk);

    run_cmd(`UBM_CMD_RD, no_par);                    // reset length and address
    run_cmd(`UBM_CMD_LEN, '{8'h01, 8'h00});
    run_cmd(`UBM_CMD_ADD, '{8'h00, 8'h00, 8'h00, 8'h00});

    // random block write, then read back
    base = $random(seed);
    for (int i = 0; i < 8; i++) data.push_back(8'($random(seed)));
    run_cmd(`UBM_CMD_LEN, '{8'h08, 8'h00});
    run_cmd(`UBM_CMD_ADD, '{base[7:0], base[15:8], base[23:16], base[31:24]});
    run_cmd(`UBM_CMD_WR, data);
    run_cmd(`UBM_CMD_RD, no_par);

    run_cmd(8'h5A, no_par);                          // not a command
    run_cmd(`UBM_CMD_LEN, '{8'h00, 8'h00});
    run_cmd(`UBM_CMD_RD, no_par);
    run_cmd(`UBM_CMD_WR, no_par);

    repeat (20) @(negedge clk);
    assert (exp_bus_q.size() == 0) else begin
      $display("%0d expected bus strobes never appeared", exp_bus_q.size());
      err_bus++;
    end
    report_counts();
    if (err_data + err_bus == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: include/ubm_defines.svh
//**************************************************************************
// shared constants of the serial bus bridge
// oversampling, read wait, command codes, answer bytes, reset length
//**************************************************************************
`ifndef UBM_DEFINES_SVH
`define UBM_DEFINES_SVH

`define UBM_OVERSAMPLE 4   // clk cycles per serial bit
`define UBM_RD_WAIT    2   // bus_rd rise to data sample

// answer "OK\r"
`define UBM_ACK0 8'h4F
`define UBM_ACK1 8'h4B
`define UBM_ACK2 8'h0D

`define UBM_CMD_LEN 8'h6C  // 'l'
`define UBM_CMD_ADD 8'h61  // 'a'
`define UBM_CMD_RD  8'h72  // 'r'
`define UBM_CMD_WR  8'h77  // 'w'

`define UBM_LEN_RST 1
`endif

// File: logic/ubm_addr_gen.sv
//**************************************************************************
// block length and base address registers, loaded bytewise
// offset counter, current bus address and block end flag
//**************************************************************************
`include "ubm_defines.svh"

module ubm_addr_gen (
  input  logic                  clk,
  input  logic                  UART_RST,
  input  ubm_pkg::ubm_agen_op_t op,
  output ubm_pkg::addr_t        cur_add,
  output logic                  blk_end
);

  ubm_pkg::len_t  len_q;
  ubm_pkg::addr_t add_q;
  ubm_pkg::len_t  off_q;   // bytes done in the current block

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      len_q <= ubm_pkg::len_t'(`UBM_LEN_RST);
      add_q <= '0;
    end else begin
      if (op.load_len) begin
        len_q[{op.idx[0], 3'b000} +: 8] <= op.val;   // two lanes only
      end
      if (op.load_add) begin
        add_q[{op.idx, 3'b000} +: 8] <= op.val;
      end
    end
  end

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      off_q <= '0;
    end else if (op.clear) begin
      off_q <= '0;
    end else if (op.step) begin
      off_q <= off_q + 1'b1;
    end
  end

  assign cur_add = add_q + ubm_pkg::addr_t'(off_q);
  assign blk_end = (off_q == len_q);  // also true at once for length 0

endmodule

// File: logic/ubm_cmd_ctrl.sv
//**************************************************************************
// command FSM: decodes l/a/w/r, feeds the address generator,
// issues bus writes and reads, sends read data and the OK answer
//**************************************************************************
`include "ubm_defines.svh"

module ubm_cmd_ctrl (
  input  logic                  clk,
  input  logic                  UART_RST,
  input  logic                  rx_valid,
  input  ubm_pkg::byte_t        rx_byte,
  input  logic                  tx_ready,
  output logic                  tx_valid,
  output ubm_pkg::byte_t        tx_byte,
  output ubm_pkg::ubm_agen_op_t agen_op,
  input  ubm_pkg::addr_t        cur_add,
  input  logic                  blk_end,
  input  ubm_pkg::byte_t        bus_rdata,
  output ubm_pkg::ubm_bus_req_t bus_req
);

  ubm_pkg::ubm_state_e state;
  logic [1:0]          cnt;        // parameter byte or answer byte index
  logic [1:0]          wait_cnt;
  logic                tx_fire;
  ubm_pkg::byte_t      ack_next;

  assign tx_fire  = tx_valid & tx_ready;
  assign ack_next = (cnt == 2'd0) ? `UBM_ACK1 : `UBM_ACK2;

  // address generator acts in the same cycle
  always_comb begin
    agen_op     = '0;
    agen_op.idx = cnt;
    agen_op.val = rx_byte;
    case (state)
      ubm_pkg::IDLE: begin
        agen_op.clear = rx_valid && (rx_byte == `UBM_CMD_WR || rx_byte == `UBM_CMD_RD);
      end
      ubm_pkg::SET_LEN: agen_op.load_len = rx_valid;
      ubm_pkg::SET_ADD: agen_op.load_add = rx_valid;
      ubm_pkg::WRITE:   agen_op.step     = rx_valid && !blk_end;
      ubm_pkg::READ:    agen_op.step     = !blk_end;
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      state    <= ubm_pkg::IDLE;
      cnt      <= '0;
      wait_cnt <= '0;
      tx_valid <= 1'b0;
      tx_byte  <= '0;
      bus_req  <= '0;
    end else begin
      bus_req.wr <= 1'b0;   // strobes last one cycle
      bus_req.rd <= 1'b0;
      case (state)
        ubm_pkg::IDLE: begin
          if (rx_valid) begin
            cnt <= '0;
            case (rx_byte)
              `UBM_CMD_LEN: state <= ubm_pkg::SET_LEN;
              `UBM_CMD_ADD: state <= ubm_pkg::SET_ADD;
              `UBM_CMD_WR:  state <= ubm_pkg::WRITE;
              `UBM_CMD_RD:  state <= ubm_pkg::READ;
              default: ;    // unknown letter, no answer
            endcase
          end
        end
        ubm_pkg::SET_LEN, ubm_pkg::SET_ADD: begin
          if (rx_valid) begin
            cnt <= cnt + 1'b1;
            if (cnt == ((state == ubm_pkg::SET_LEN) ? 2'd1 : 2'd3)) begin
              state    <= ubm_pkg::ACK;
              cnt      <= '0;
              tx_valid <= 1'b1;
              tx_byte  <= `UBM_ACK0;
            end
          end
        end
        ubm_pkg::WRITE: begin
          if (blk_end) begin
            state    <= ubm_pkg::ACK;
            tx_valid <= 1'b1;
            tx_byte  <= `UBM_ACK0;
          end else if (rx_valid) begin
            bus_req.wr    <= 1'b1;
            bus_req.add   <= cur_add;   // offset steps in the same edge
            bus_req.wdata <= rx_byte;
          end
        end
        ubm_pkg::READ: begin
          if (blk_end) begin
            state    <= ubm_pkg::ACK;
            tx_valid <= 1'b1;
            tx_byte  <= `UBM_ACK0;
          end else begin
            bus_req.rd  <= 1'b1;
            bus_req.add <= cur_add;
            wait_cnt    <= '0;
            state       <= ubm_pkg::READ_WAIT;
          end
        end
        ubm_pkg::READ_WAIT: begin
          if (tx_valid) begin
            if (tx_ready) begin
              tx_valid <= 1'b0;
              state    <= ubm_pkg::READ;   // next byte only after this one left
            end
          end else if (wait_cnt == 2'(`UBM_RD_WAIT - 1)) begin
            tx_byte  <= bus_rdata;
            tx_valid <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ubm_pkg::ACK: begin
          if (tx_fire) begin
            if (cnt == 2'd2) begin
              tx_valid <= 1'b0;
              state    <= ubm_pkg::IDLE;
            end else begin
              cnt     <= cnt + 1'b1;
              tx_byte <= ack_next;
            end
          end
        end
        default: state <= ubm_pkg::IDLE;
      endcase
    end
  end

  a_no_wr_rd: assert property (@(posedge clk) disable iff (UART_RST)
    !(bus_req.wr && bus_req.rd));

endmodule

// File: logic/ubm_pkg.sv
//**************************************************************************
// bridge types: byte, address and length vectors
// controller state enum, bus request and address generator command
//**************************************************************************
package ubm_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] addr_t;
  typedef logic [15:0] len_t;

  typedef enum logic [2:0] {
    IDLE,
    SET_LEN,
    SET_ADD,
    WRITE,
    READ,
    READ_WAIT,
    ACK
  } ubm_state_e;

  // one bus cycle, registered in the controller
  typedef struct packed {
    logic  wr;
    logic  rd;
    addr_t add;
    byte_t wdata;
  } ubm_bus_req_t;

  typedef struct packed {
    logic       load_len;
    logic       load_add;
    logic [1:0] idx;    // byte lane of the loaded register
    byte_t      val;
    logic       clear;  // offset back to zero
    logic       step;   // offset plus one
  } ubm_agen_op_t;

endpackage

// File: logic/ubm_top.sv
//**************************************************************************
// serial bus bridge top: receiver, transmitter, address generator,
// command FSM and the tri-state data line
//**************************************************************************
module ubm_top (
  input  logic           clk,
  input  logic           UART_RST,
  input  logic           rx,
  output logic           tx,
  inout  ubm_pkg::byte_t bus_data,
  output ubm_pkg::addr_t bus_add,
  output logic           bus_wr,
  output logic           bus_rd
);

  logic                  rx_valid;
  ubm_pkg::byte_t        rx_byte;
  logic                  tx_valid;
  logic                  tx_ready;
  ubm_pkg::byte_t        tx_byte;
  ubm_pkg::ubm_agen_op_t agen_op;
  ubm_pkg::addr_t        cur_add;
  logic                  blk_end;
  ubm_pkg::ubm_bus_req_t bus_req;

  assign bus_add  = bus_req.add;
  assign bus_wr   = bus_req.wr;
  assign bus_rd   = bus_req.rd;
  assign bus_data = bus_req.wr ? bus_req.wdata : 'z;   // released unless writing

  ubm_uart_rx i_rx (
    .clk(clk), .UART_RST(UART_RST), .rx(rx), .rx_valid(rx_valid), .rx_byte(rx_byte)
  );

  ubm_uart_tx i_tx (
    .clk(clk), .UART_RST(UART_RST), .tx_valid(tx_valid), .tx_byte(tx_byte),
    .tx_ready(tx_ready), .tx(tx)
  );

  ubm_addr_gen i_agen (
    .clk(clk), .UART_RST(UART_RST), .op(agen_op), .cur_add(cur_add), .blk_end(blk_end)
  );

  ubm_cmd_ctrl i_ctrl (
    .clk(clk), .UART_RST(UART_RST), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .tx_ready(tx_ready), .tx_valid(tx_valid), .tx_byte(tx_byte), .agen_op(agen_op),
    .cur_add(cur_add), .blk_end(blk_end), .bus_rdata(bus_data), .bus_req(bus_req)
  );

endmodule

// File: logic/ubm_uart_rx.sv
//**************************************************************************
// oversampled serial receiver, 8 data bits, lsb first
// start bit recheck at mid-bit, framing error drops the byte
//**************************************************************************
`include "ubm_defines.svh"

module ubm_uart_rx (
  input  logic           clk,
  input  logic           UART_RST,
  input  logic           rx,
  output logic           rx_valid,
  output ubm_pkg::byte_t rx_byte
);

  localparam int unsigned PH_W = $clog2(`UBM_OVERSAMPLE);

  logic            rx_s1;
  logic            rx_s2;
  logic            rx_s3;     // previous rx_s2, for edge detect
  logic            fall;
  logic            busy;
  logic [PH_W-1:0] phase;     // counts down to the next sample point
  logic [3:0]      bit_idx;   // 0 start, 1..8 data, 9 stop
  logic            sample;

  assign fall   = rx_s3 & ~rx_s2;
  assign sample = busy && (phase == '0);

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
    end
  end

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      busy     <= 1'b0;
      phase    <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (fall) begin
          busy    <= 1'b1;
          phase   <= PH_W'(`UBM_OVERSAMPLE / 2 - 1);  // first sample mid start bit
          bit_idx <= '0;
        end
      end else if (!sample) begin
        phase <= phase - 1'b1;
      end else begin
        phase   <= PH_W'(`UBM_OVERSAMPLE - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_s2) begin
          busy <= 1'b0;        // glitch, line back high
        end else if (bit_idx == 4'd9) begin
          busy     <= 1'b0;
          rx_valid <= rx_s2;   // low stop bit, no strobe
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
      rx_byte <= {rx_s2, rx_byte[7:1]};
    end
  end

  a_rx_valid_pulse: assert property (@(posedge clk) disable iff (UART_RST)
    rx_valid |=> !rx_valid);

endmodule

// File: logic/ubm_uart_tx.sv
//**************************************************************************
// serial transmitter, start + 8 data + stop
// byte taken on tx_valid and tx_ready, ready again after the stop bit
//**************************************************************************
`include "ubm_defines.svh"

module ubm_uart_tx (
  input  logic           clk,
  input  logic           UART_RST,
  input  logic           tx_valid,
  input  ubm_pkg::byte_t tx_byte,
  output logic           tx_ready,
  output logic           tx
);

  localparam int unsigned PH_W = $clog2(`UBM_OVERSAMPLE);

  logic [9:0]      shreg;     // all ones while idle
  logic            busy;
  logic [PH_W-1:0] phase;
  logic [3:0]      bit_idx;

  assign tx_ready = ~busy;
  assign tx       = shreg[0];

  always_ff @(posedge clk or posedge UART_RST) begin
    if (UART_RST) begin
      shreg   <= '1;
      busy    <= 1'b0;
      phase   <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      if (tx_valid) begin
        shreg   <= {1'b1, tx_byte, 1'b0};
        busy    <= 1'b1;
        phase   <= '0;
        bit_idx <= '0;
      end
    end else if (phase != PH_W'(`UBM_OVERSAMPLE - 1)) begin
      phase <= phase + 1'b1;
    end else begin
      phase <= '0;
      shreg <= {1'b1, shreg[9:1]};  // shift in idle level
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // a pending byte stays offered and unchanged
  a_tx_hold: assert property (@(posedge clk) disable iff (UART_RST)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

endmodule

// File: uart_bus_master.f
+incdir+include
logic/ubm_pkg.sv
logic/ubm_uart_rx.sv
logic/ubm_uart_tx.sv
logic/ubm_addr_gen.sv
logic/ubm_cmd_ctrl.sv
logic/ubm_top.sv
bench/ubm_tb.sv
